// ==== rtl/rv_cfg.svh ====
// --------------------
// RV32I core sizing
// --------------------
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Data and address width
`define RV_XLEN 32

// Register index width and count
`define RV_REG_ADDR_W 5
`define RV_NUM_REGS 32

// First fetch address after reset
`define RV_RESET_PC 32'h8000_0000

// Byte strobes per bus word
`define RV_MASK_W 4

`endif

// ==== rtl/rv_pkg.sv ====
// --------------------
// RV32I core types
// --------------------
`include "rv_cfg.svh"

package rv_pkg;

    // Major opcodes
    localparam logic [6:0] OP     = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] LOAD   = 7'b0000011;
    localparam logic [6:0] STORE  = 7'b0100011;
    localparam logic [6:0] BRANCH = 7'b1100011;
    localparam logic [6:0] JAL    = 7'b1101111;
    localparam logic [6:0] JALR   = 7'b1100111;
    localparam logic [6:0] LUI    = 7'b0110111;
    localparam logic [6:0] AUIPC  = 7'b0010111;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE  // Unknown opcode
    } fmt_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic [6:0]                funct7;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]               imm;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]                imm_hi;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [4:0]                imm_lo;
        logic [6:0]                opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                      imm_12;
        logic [5:0]                imm_10_5;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [3:0]                imm_4_1;
        logic                      imm_11;
        logic [6:0]                opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]               imm;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                      imm_20;
        logic [9:0]                imm_10_1;
        logic                      imm_11;
        logic [7:0]                imm_19_12;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } j_fmt_t;

    // One instruction word, seen through every format
    typedef union packed {
        r_fmt_t              r;
        i_fmt_t              i;
        s_fmt_t              s;
        b_fmt_t              b;
        u_fmt_t              u;
        j_fmt_t              j;
        logic [`RV_XLEN-1:0] raw;
    } inst_u;

endpackage

// ==== rtl/rv_fetch.sv ====
// --------------------
// PC and phase sequencer
// --------------------
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_fetch (
    input  logic                clk,
    input  logic                reset,
    input  logic                inst_valid,
    input  logic                mem_done,
    input  logic                is_mem,
    input  logic [`RV_XLEN-1:0] next_pc,
    output logic                fetch_req,
    output logic [`RV_XLEN-1:0] pc,
    output logic                phase_exec,
    output logic                phase_mem,
    output logic                phase_wb
);

    // One-hot phase encoding
    localparam logic [3:0] PH_FETCH = 4'b0001;
    localparam logic [3:0] PH_EXEC  = 4'b0010;
    localparam logic [3:0] PH_MEM   = 4'b0100;
    localparam logic [3:0] PH_WB    = 4'b1000;

    logic [3:0] phase;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase     <= PH_FETCH;
            fetch_req <= 1'b0;  // Raised on the first edge out of reset
            pc        <= `RV_RESET_PC;
        end else begin
            unique case (phase)
                PH_FETCH: begin
                    fetch_req <= ~inst_valid;
                    if (inst_valid) begin
                        phase <= PH_EXEC;
                    end
                end
                PH_EXEC: phase <= is_mem ? PH_MEM : PH_WB;
                PH_MEM: begin
                    if (mem_done) begin
                        phase <= PH_WB;
                    end
                end
                default: begin  // WB retires and starts the next fetch
                    phase     <= PH_FETCH;
                    fetch_req <= 1'b1;
                    pc        <= next_pc;
                end
            endcase
        end
    end

    assign phase_exec = phase[1];
    assign phase_mem  = phase[2];
    assign phase_wb   = phase[3];

    a_one_phase: assert property (@(posedge clk) disable iff (reset) $onehot(phase));

    // Instruction words only come back while a fetch is open
    a_inst_in_fetch: assert property (@(posedge clk) disable iff (reset)
        inst_valid |-> (phase == PH_FETCH) && fetch_req);

endmodule

// ==== rtl/rv_decode.sv ====
// --------------------
// Instruction decoder
// --------------------
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decode (
    input  rv_pkg::inst_u              inst,
    output rv_pkg::fmt_e               fmt,
    output rv_pkg::alu_op_e            alu_op,
    output logic [`RV_XLEN-1:0]        imm,
    output logic [`RV_REG_ADDR_W-1:0]  rs1,
    output logic [`RV_REG_ADDR_W-1:0]  rs2,
    output logic [`RV_REG_ADDR_W-1:0]  rd,
    output logic                       writes_rd,
    output logic                       is_load,
    output logic                       is_store
);

    logic [6:0] opcode;

    assign opcode   = inst.r.opcode;
    assign rs1      = inst.r.rs1;
    assign rs2      = inst.r.rs2;
    assign rd       = inst.r.rd;
    assign is_load  = (opcode == rv_pkg::LOAD);
    assign is_store = (opcode == rv_pkg::STORE);

    always_comb begin
        unique case (opcode)
            rv_pkg::OP:                                  fmt = rv_pkg::FMT_R;
            rv_pkg::OP_IMM, rv_pkg::LOAD, rv_pkg::JALR:  fmt = rv_pkg::FMT_I;
            rv_pkg::STORE:                               fmt = rv_pkg::FMT_S;
            rv_pkg::BRANCH:                              fmt = rv_pkg::FMT_B;
            rv_pkg::LUI, rv_pkg::AUIPC:                  fmt = rv_pkg::FMT_U;
            rv_pkg::JAL:                                 fmt = rv_pkg::FMT_J;
            default:                                     fmt = rv_pkg::FMT_NONE;
        endcase
    end

    // Branches, stores and unknown opcodes leave rd alone
    assign writes_rd = fmt inside {rv_pkg::FMT_R, rv_pkg::FMT_I, rv_pkg::FMT_U, rv_pkg::FMT_J};

    always_comb begin
        unique case (fmt)
            rv_pkg::FMT_I: imm = {{(`RV_XLEN-12){inst.i.imm[11]}}, inst.i.imm};
            rv_pkg::FMT_S: imm = {{(`RV_XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            rv_pkg::FMT_B: imm = {{(`RV_XLEN-12){inst.b.imm_12}}, inst.b.imm_11,
                                  inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            rv_pkg::FMT_U: imm = {inst.u.imm, 12'b0};
            rv_pkg::FMT_J: imm = {{(`RV_XLEN-20){inst.j.imm_20}}, inst.j.imm_19_12,
                                  inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            default:       imm = '0;
        endcase
    end

    always_comb begin
        alu_op = rv_pkg::ALU_ADD;  // Address and link arithmetic
        if (opcode == rv_pkg::OP || opcode == rv_pkg::OP_IMM) begin
            unique case (inst.r.funct3)
                3'b000: begin
                    if (opcode == rv_pkg::OP && inst.r.funct7[5]) begin
                        alu_op = rv_pkg::ALU_SUB;
                    end
                end
                3'b001:  alu_op = rv_pkg::ALU_SLL;
                3'b010:  alu_op = rv_pkg::ALU_SLT;
                3'b011:  alu_op = rv_pkg::ALU_SLTU;
                3'b100:  alu_op = rv_pkg::ALU_XOR;
                3'b101:  alu_op = inst.r.funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'b110:  alu_op = rv_pkg::ALU_OR;
                default: alu_op = rv_pkg::ALU_AND;
            endcase
        end
    end

endmodule

// ==== rtl/rv_regfile.sv ====
// --------------------
// General register file
// --------------------
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_regfile (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      we,
    input  logic [`RV_REG_ADDR_W-1:0] waddr,
    input  logic [`RV_XLEN-1:0]       wdata,
    input  logic [`RV_REG_ADDR_W-1:0] raddr1,
    input  logic [`RV_REG_ADDR_W-1:0] raddr2,
    output logic [`RV_XLEN-1:0]       rdata1,
    output logic [`RV_XLEN-1:0]       rdata2
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // x0 is never written
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    a_x0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

// ==== rtl/rv_execute.sv ====
// --------------------
// Execute unit
// --------------------
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_execute (
    input  rv_pkg::inst_u       inst,
    input  rv_pkg::fmt_e        fmt,
    input  rv_pkg::alu_op_e     alu_op,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] rs1_val,
    input  logic [`RV_XLEN-1:0] rs2_val,
    input  logic [`RV_XLEN-1:0] load_data,
    output logic [`RV_XLEN-1:0] alu_result,
    output logic [`RV_XLEN-1:0] next_pc,
    output logic [`RV_XLEN-1:0] rd_value
);

    logic [6:0]          opcode;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] link;
    logic [4:0]          shamt;
    logic                taken;

    assign opcode = inst.r.opcode;
    assign link   = pc + `RV_XLEN'd4;
    assign shamt  = op_b[4:0];

    always_comb begin
        unique case (fmt)
            rv_pkg::FMT_R: begin
                op_a = rs1_val;
                op_b = rs2_val;
            end
            rv_pkg::FMT_U: begin
                op_a = (opcode == rv_pkg::LUI) ? '0 : pc;
                op_b = imm;
            end
            rv_pkg::FMT_B, rv_pkg::FMT_J: begin  // PC-relative targets
                op_a = pc;
                op_b = imm;
            end
            default: begin  // I, S and unknown
                op_a = rs1_val;
                op_b = imm;
            end
        endcase
    end

    always_comb begin
        unique case (alu_op)
            rv_pkg::ALU_SUB:  alu_result = op_a - op_b;
            rv_pkg::ALU_SLL:  alu_result = op_a << shamt;
            rv_pkg::ALU_SLT:  alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU: alu_result = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            rv_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
            rv_pkg::ALU_SRL:  alu_result = op_a >> shamt;
            rv_pkg::ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:   alu_result = op_a | op_b;
            rv_pkg::ALU_AND:  alu_result = op_a & op_b;
            default:          alu_result = op_a + op_b;
        endcase
    end

    // Branch condition from funct3
    always_comb begin
        unique case (inst.b.funct3)
            3'b000:  taken = (rs1_val == rs2_val);
            3'b001:  taken = (rs1_val != rs2_val);
            3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));
            3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            3'b110:  taken = (rs1_val < rs2_val);
            3'b111:  taken = (rs1_val >= rs2_val);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (opcode == rv_pkg::JAL || (opcode == rv_pkg::BRANCH && taken)) begin
            next_pc = alu_result;
        end else if (opcode == rv_pkg::JALR) begin
            next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
        end else begin
            next_pc = link;  // Also unknown opcodes
        end
    end

    always_comb begin
        if (opcode == rv_pkg::JAL || opcode == rv_pkg::JALR) begin
            rd_value = link;
        end else if (opcode == rv_pkg::LOAD) begin
            rd_value = load_data;
        end else begin
            rd_value = alu_result;
        end
    end

endmodule

// ==== rtl/rv_lsu.sv ====
// --------------------
// Load-store unit and bus
// --------------------
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_lsu (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fetch_req,
    input  logic [`RV_XLEN-1:0]   pc,
    input  logic                  phase_mem,
    input  logic                  is_load,
    input  logic                  is_store,
    input  logic [2:0]            funct3,
    input  logic [`RV_XLEN-1:0]   addr,
    input  logic [`RV_XLEN-1:0]   store_data,
    input  logic                  bus_ready,
    input  logic [`RV_XLEN-1:0]   bus_rdata,
    input  logic                  bus_rvalid,
    output rv_pkg::inst_u         inst,
    output logic                  inst_valid,
    output logic                  mem_done,
    output logic [`RV_XLEN-1:0]   load_data,
    output logic                  bus_req,
    output logic                  bus_we,
    output logic [`RV_XLEN-1:0]   bus_addr,
    output logic [`RV_XLEN-1:0]   bus_wdata,
    output logic [`RV_MASK_W-1:0] bus_wmask
);

    logic                  rd_pending;  // Read accepted, data not back yet
    logic                  data_sel;
    logic                  accept;
    logic [1:0]            lane;
    logic [`RV_MASK_W-1:0] size_mask;
    logic [`RV_XLEN-1:0]   rdata_lane;
    logic [`RV_XLEN-1:0]   load_ext;

    assign data_sel = phase_mem & (is_load | is_store);
    assign lane     = addr[1:0];
    assign accept   = bus_req & bus_ready;

    assign bus_req   = (fetch_req | data_sel) & ~rd_pending;
    assign bus_we    = data_sel & is_store;
    assign bus_addr  = data_sel ? addr : pc;
    assign bus_wdata = bus_we ? store_data << {lane, 3'b000} : '0;
    assign bus_wmask = bus_we ? size_mask << lane : '0;

    always_comb begin
        unique case (funct3[1:0])
            2'b00:   size_mask = `RV_MASK_W'h1;
            2'b01:   size_mask = `RV_MASK_W'h3;
            default: size_mask = `RV_MASK_W'hF;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_pending <= 1'b0;
        end else if (accept && !bus_we) begin
            rd_pending <= 1'b1;
        end else if (bus_rvalid) begin
            rd_pending <= 1'b0;
        end
    end

    // Phase tells a fetch response from a load response
    assign inst_valid = bus_rvalid & rd_pending & ~phase_mem;
    assign mem_done   = phase_mem & ((accept & bus_we) | (bus_rvalid & rd_pending));

    assign rdata_lane = bus_rdata >> {lane, 3'b000};

    always_comb begin
        unique case (funct3)
            3'b000:  load_ext = {{(`RV_XLEN-8){rdata_lane[7]}}, rdata_lane[7:0]};
            3'b001:  load_ext = {{(`RV_XLEN-16){rdata_lane[15]}}, rdata_lane[15:0]};
            3'b100:  load_ext = {{(`RV_XLEN-8){1'b0}}, rdata_lane[7:0]};
            3'b101:  load_ext = {{(`RV_XLEN-16){1'b0}}, rdata_lane[15:0]};
            default: load_ext = rdata_lane;  // LW
        endcase
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            inst.raw <= bus_rdata;
        end
        if (bus_rvalid && rd_pending && phase_mem) begin
            load_data <= load_ext;
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        bus_req && !bus_ready |=> bus_req && $stable(bus_we) && $stable(bus_addr)
            && $stable(bus_wdata) && $stable(bus_wmask));

endmodule

// ==== rtl/rv_core.sv ====
// --------------------
// RV32I core top level
// --------------------
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  bus_ready,
    input  logic [`RV_XLEN-1:0]   bus_rdata,
    input  logic                  bus_rvalid,
    output logic                  bus_req,
    output logic                  bus_we,
    output logic [`RV_XLEN-1:0]   bus_addr,
    output logic [`RV_XLEN-1:0]   bus_wdata,
    output logic [`RV_MASK_W-1:0] bus_wmask
);

    rv_pkg::inst_u             inst;
    rv_pkg::fmt_e              fmt;
    rv_pkg::alu_op_e           alu_op;
    logic                      inst_valid;
    logic                      mem_done;
    logic                      fetch_req;
    logic                      phase_exec;
    logic                      phase_mem;
    logic                      phase_wb;
    logic                      writes_rd;
    logic                      is_load;
    logic                      is_store;
    logic [`RV_XLEN-1:0]       pc;
    logic [`RV_XLEN-1:0]       next_pc;
    logic [`RV_XLEN-1:0]       imm;
    logic [`RV_XLEN-1:0]       rs1_val;
    logic [`RV_XLEN-1:0]       rs2_val;
    logic [`RV_XLEN-1:0]       alu_result;
    logic [`RV_XLEN-1:0]       rd_value;
    logic [`RV_XLEN-1:0]       load_data;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rd;

    rv_fetch u_fetch (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .mem_done   (mem_done),
        .is_mem     (phase_exec & (is_load | is_store)),
        .next_pc    (next_pc),
        .fetch_req  (fetch_req),
        .pc         (pc),
        .phase_exec (phase_exec),
        .phase_mem  (phase_mem),
        .phase_wb   (phase_wb)
    );

    rv_decode u_decode (
        .inst      (inst),
        .fmt       (fmt),
        .alu_op    (alu_op),
        .imm       (imm),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .writes_rd (writes_rd),
        .is_load   (is_load),
        .is_store  (is_store)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .we     (phase_wb & writes_rd),  // Written on the edge that ends WB
        .waddr  (rd),
        .wdata  (rd_value),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    rv_execute u_execute (
        .inst       (inst),
        .fmt        (fmt),
        .alu_op     (alu_op),
        .imm        (imm),
        .pc         (pc),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .load_data  (load_data),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .rd_value   (rd_value)
    );

    rv_lsu u_lsu (
        .clk        (clk),
        .reset      (reset),
        .fetch_req  (fetch_req),
        .pc         (pc),
        .phase_mem  (phase_mem),
        .is_load    (is_load),
        .is_store   (is_store),
        .funct3     (inst.r.funct3),
        .addr       (alu_result),
        .store_data (rs2_val),
        .bus_ready  (bus_ready),
        .bus_rdata  (bus_rdata),
        .bus_rvalid (bus_rvalid),
        .inst       (inst),
        .inst_valid (inst_valid),
        .mem_done   (mem_done),
        .load_data  (load_data),
        .bus_req    (bus_req),
        .bus_we     (bus_we),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_wmask  (bus_wmask)
    );

endmodule

// ==== test/rv_core_tb.sv ====
// --------------------
// RV32I core testbench
// --------------------
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core_tb;

    localparam int NUM_INST     = 400;
    localparam int RESET_CYCLES = 8;

    logic                  clk;
    logic                  reset;
    logic                  bus_ready;
    logic [`RV_XLEN-1:0]   bus_rdata;
    logic                  bus_rvalid;
    logic                  bus_req;
    logic                  bus_we;
    logic [`RV_XLEN-1:0]   bus_addr;
    logic [`RV_XLEN-1:0]   bus_wdata;
    logic [`RV_MASK_W-1:0] bus_wmask;

    logic [7:0]  mem [bit [31:0]];  // Sparse byte memory
    logic [31:0] lfsr;
    logic [31:0] xr [32];           // Model registers
    logic [31:0] model_pc;
    logic        exp_we;
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;
    logic [3:0]  exp_mask;
    logic        data_next;         // Data access expected before the next fetch
    int          val_errors;
    int          seq_errors;
    int          retired;

    rv_core dut (
        .clk        (clk),
        .reset      (reset),
        .bus_ready  (bus_ready),
        .bus_rdata  (bus_rdata),
        .bus_rvalid (bus_rvalid),
        .bus_req    (bus_req),
        .bus_we     (bus_we),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_wmask  (bus_wmask)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] random_inst();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] off;
        r   = rand_bits(4) % 9;
        f3  = 3'(rand_bits(3));
        rd  = 5'(rand_bits(5));
        rs1 = 5'(rand_bits(5));
        rs2 = 5'(rand_bits(5));
        off = 12'h100 + 12'(rand_bits(8));  // Data window 0x100 to 0x1ff
        case (r)
            0: return {(f3 == 3'd0 || f3 == 3'd5) ? {1'b0, rand_bits(1) == 1, 5'b0} : 7'b0,
                       rs2, rs1, f3, rd, 7'b0110011};
            1: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    return {1'b0, f3 == 3'd5 && rand_bits(1) == 1, 5'b0, rs2, rs1, f3, rd,
                            7'b0010011};
                end
                return {12'(rand_bits(12)), rs1, f3, rd, 7'b0010011};
            end
            2: begin
                if (f3 == 3'd3 || f3 > 3'd5) f3 = 3'd2;
                off = (f3[1:0] == 2'd0) ? off : (f3[1:0] == 2'd1) ? {off[11:1], 1'b0} :
                      {off[11:2], 2'b0};
                return {off, 5'd0, f3, rd, 7'b0000011};
            end
            3: begin
                f3 = {1'b0, (f3[1:0] == 2'd3) ? 2'd2 : f3[1:0]};
                off = (f3 == 3'd0) ? off : (f3 == 3'd1) ? {off[11:1], 1'b0} : {off[11:2], 2'b0};
                return {off[11:5], rs2, 5'd0, f3, off[4:0], 7'b0100011};
            end
            4: begin
                if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd0;
                return {7'(rand_bits(7)), rs2, rs1, f3, 5'(rand_bits(5)), 7'b1100011};
            end
            5: return {20'(rand_bits(20)), rd, 7'b1101111};
            6: return {12'(rand_bits(12)), rs1, 3'b000, rd, 7'b1100111};
            7: return {20'(rand_bits(20)), rd, 7'b0110111};
            default: return {20'(rand_bits(20)), rd, 7'b0010111};
        endcase
    endfunction

    // Word read, filled on first touch; low addresses hold data
    function automatic logic [31:0] get_word(input logic [31:0] a);
        logic [31:0] w;
        logic [31:0] base;
        base = {a[31:2], 2'b00};
        if (!mem.exists(base)) begin
            w = (base < 32'h1000) ? rand_bits(32) : random_inst();
            for (int i = 0; i < 4; i++) begin
                mem[base + i] = w[8*i +: 8];
            end
        end
        return {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
    endfunction

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Runs one instruction and sets up the next expected bus request
    task automatic model_step();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] v;
        logic [31:0] npc;
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] imm_i;
        logic        wr;
        logic        take;
        w     = get_word(model_pc);
        s1    = xr[w[19:15]];
        s2    = xr[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        npc   = model_pc + 4;
        wr    = 1'b1;
        v     = '0;
        data_next = 1'b0;
        case (w[6:0])
            7'h37: v = {w[31:12], 12'b0};
            7'h17: v = model_pc + {w[31:12], 12'b0};
            7'h6f: begin
                v   = model_pc + 4;
                npc = model_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'h67: begin
                v   = model_pc + 4;
                npc = (s1 + imm_i) & ~32'd1;
            end
            7'h63: begin
                wr = 1'b0;
                case (w[14:12])
                    3'd0: take = s1 == s2;
                    3'd1: take = s1 != s2;
                    3'd4: take = $signed(s1) < $signed(s2);
                    3'd5: take = $signed(s1) >= $signed(s2);
                    3'd6: take = s1 < s2;
                    3'd7: take = s1 >= s2;
                    default: take = 1'b0;
                endcase
                if (take) npc = model_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            7'h03: begin
                a = s1 + imm_i;
                v = get_word(a) >> (8 * a[1:0]);
                case (w[14:12])
                    3'd0: v = {{24{v[7]}}, v[7:0]};
                    3'd1: v = {{16{v[15]}}, v[15:0]};
                    3'd4: v = {24'b0, v[7:0]};
                    3'd5: v = {16'b0, v[15:0]};
                    default: v = v;
                endcase
                data_next = 1'b1;
                exp_we    = 1'b0;
                exp_addr  = a;
                exp_wdata = '0;
                exp_mask  = '0;
            end
            7'h23: begin
                wr = 1'b0;
                a  = s1 + {{20{w[31]}}, w[31:25], w[11:7]};
                data_next = 1'b1;
                exp_we    = 1'b1;
                exp_addr  = a;
                exp_wdata = s2 << (8 * a[1:0]);
                exp_mask  = ((w[13:12] == 2'd0) ? 4'h1 : (w[13:12] == 2'd1) ? 4'h3 : 4'hf)
                            << a[1:0];
            end
            7'h13, 7'h33: begin
                v = alu(w[14:12], w[30] && (w[5] || w[14:12] == 3'd5), s1, w[5] ? s2 : imm_i);
            end
            default: wr = 1'b0;  // No-op
        endcase
        if (wr && w[11:7] != 5'd0) xr[w[11:7]] = v;
        model_pc = npc;
    endtask

    // A fetch retires one instruction, a data access leads back to fetch
    task automatic advance_model();
        if (data_next) begin
            data_next = 1'b0;
        end else begin
            retired++;
            model_step();
        end
        if (!data_next) begin
            exp_we    = 1'b0;
            exp_addr  = model_pc;
            exp_wdata = '0;
            exp_mask  = '0;
        end
    endtask

    task automatic check_request(input logic we, input logic [31:0] addr,
                                 input logic [31:0] wdata, input logic [3:0] mask);
        if (we !== exp_we || addr !== exp_addr || wdata !== exp_wdata || mask !== exp_mask) begin
            $display("** Error at %0t: exp we=%0b addr=%h data=%h mask=%h, got %0b %h %h %h",
                     $time, exp_we, exp_addr, exp_wdata, exp_mask, we, addr, wdata, mask);
            val_errors++;
        end
    endtask

    initial begin
        #((NUM_INST * 20 + RESET_CYCLES + 2) * 40);
        $display("Watchdog expired after %0d instructions, the core hangs", retired);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic        waiting;
        logic        h_we;
        logic [31:0] h_addr;
        logic [31:0] h_wdata;
        logic [3:0]  h_mask;
        int          stall;
        int          lat;
        logic [31:0] rd_addr;
        reset      = 1'b1;
        bus_ready  = 1'b0;
        bus_rdata  = '0;
        bus_rvalid = 1'b0;
        lfsr       = 32'd90766;
        val_errors = 0;
        seq_errors = 0;
        retired    = 0;
        waiting    = 1'b0;
        lat        = 0;
        rd_addr    = '0;
        for (int i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        model_pc  = `RV_RESET_PC;
        exp_we    = 1'b0;
        exp_addr  = `RV_RESET_PC;
        exp_wdata = '0;
        exp_mask  = '0;
        data_next = 1'b0;
        stall     = rand_bits(2);
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (bus_req) begin
                $display("Request raised at %0t while reset is held", $time);
                seq_errors++;
            end
        end
        @(posedge clk);
        #2 reset = 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (!bus_req) begin
            $display("No fetch request at %0t after the first edge out of reset", $time);
            seq_errors++;
        end
        while (retired < NUM_INST) begin
            @(negedge clk);
            if (waiting && (!bus_req || bus_we !== h_we || bus_addr !== h_addr
                            || bus_wdata !== h_wdata || bus_wmask !== h_mask)) begin
                $display("Request at %0t changed or dropped while waiting for ready", $time);
                seq_errors++;
            end
            waiting = bus_req && !bus_ready;
            h_we    = bus_we;
            h_addr  = bus_addr;
            h_wdata = bus_wdata;
            h_mask  = bus_wmask;
            if (bus_req && bus_ready) begin
                check_request(bus_we, bus_addr, bus_wdata, bus_wmask);
                if (bus_we) begin
                    void'(get_word(bus_addr));
                    for (int i = 0; i < 4; i++) begin
                        if (bus_wmask[i]) begin
                            mem[{bus_addr[31:2], 2'b00} + i] = bus_wdata[8*i +: 8];
                        end
                    end
                end else begin
                    rd_addr = bus_addr;
                    lat     = 1 + rand_bits(2) % 3;
                end
                advance_model();
                stall = rand_bits(2);
            end
            @(posedge clk);
            #2;
            bus_rvalid = 1'b0;
            if (lat > 0) begin
                lat--;
                if (lat == 0) begin
                    bus_rvalid = 1'b1;
                    bus_rdata  = get_word(rd_addr);
                end
            end
            if (bus_req && stall > 0) begin  // Stall only an open request
                bus_ready = 1'b0;
                stall--;
            end else begin
                bus_ready = 1'b1;
            end
        end
        $display("Value errors: %0d, sequence errors: %0d, instructions: %0d",
                 val_errors, seq_errors, retired);
        if (val_errors == 0 && seq_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== rv_core.f ====
+incdir+rtl
rtl/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_lsu.sv
rtl/rv_core.sv
test/rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the RV32I core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb -o rv_core_sim

out=$(./obj_dir/rv_core_sim)
echo "$out"

if echo "$out" | grep -q "^TEST PASS$"; then
    exit 0
fi
exit 1
